// ==== files.f ====
+incdir+include
design/lcd_pkg.sv
design/lcd_script_rom.sv
design/lcd_sequencer.sv
design/lcd_bus_writer.sv
design/lcd_display_top.sv
dv/lcd_bus_checker.sv
dv/lcd_display_tb.sv

// ==== Makefile ====
# Verilator build and run for the LCD display subsystem

VERILATOR  ?= verilator
TOP        ?= lcd_display_tb
RTL_TOP    ?= lcd_display_top
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= -Wall
PASS_TEXT  ?= TEST PASSED

SOURCES    := $(shell grep -v '^+' $(FILELIST))
HEADERS    := include/lcd_params.svh
RTL_FILES  := $(filter design/%,$(SOURCES))
SIM_BIN    := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Output kept in a shell variable, status comes from the pass line
run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) +incdir+include --top-module $(RTL_TOP) \
		$(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/lcd_display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_params.svh"

module lcd_display_tb
   import lcd_pkg::*;
();

   localparam int          CLK_PERIOD = 4;
   localparam int unsigned SEED       = 32'h2bf3_8fe4;

   // Two full scripts, then doubled for the watchdog
   localparam int SCRIPT_CYCLES = `LCD_POWERUP_CYCLES + `LCD_LONG_WAIT_CYCLES +
                                  80 * 4 * `LCD_PHASE_CYCLES;
   localparam int LIMIT_CYCLES  = 2 * (2 * SCRIPT_CYCLES);
   localparam int QUIET_CYCLES  = `LCD_POWERUP_CYCLES + `LCD_LONG_WAIT_CYCLES;

   logic        clk;
   logic        rst;
   logic        repeat_en;
   logic        lcd_e;
   logic        lcd_rs;
   lcd_nibble_t lcd_data;
   logic        done;
   logic        check_err;    // Raised by the bus checker on its first mismatch
   int          scripts_done; // Completed scripts seen on the bus

   lcd_display_top dut0 (
      .clk       (clk),
      .rst       (rst),
      .repeat_en (repeat_en),
      .lcd_e     (lcd_e),
      .lcd_rs    (lcd_rs),
      .lcd_data  (lcd_data),
      .done      (done)
   );

   lcd_bus_checker u_check (
      .clk          (clk),
      .rst          (rst),
      .lcd_e        (lcd_e),
      .lcd_rs       (lcd_rs),
      .lcd_data     (lcd_data),
      .done         (done),
      .err          (check_err),
      .scripts_done (scripts_done)
   );

   task automatic fail_run();
      $display("TEST FAILED");
      $fatal(1, "Run stopped after a failed check");
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Checker mismatch ends the run at once
   initial begin
      @(posedge check_err);
      fail_run();
   end

   initial begin
      #(LIMIT_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, done never settled", LIMIT_CYCLES);
      fail_run();
   end

   initial begin
      int repeat_at;
      rst       = 1'b1;
      repeat_en = 1'b0;
      void'($urandom(SEED));
      repeat (16) @(posedge clk);
      #1 rst = 1'b0;

      // Raise repeat somewhere inside the first script
      repeat_at = $urandom_range(600, 1);
      repeat (repeat_at) @(posedge clk);
      #1 repeat_en = 1'b1;

      while (!done) @(posedge clk);
      while (done) @(posedge clk);   // Restart drops done after one cycle
      #1 repeat_en = 1'b0;

      // Second script runs to the end and stays there
      while (!done) @(posedge clk);
      repeat (QUIET_CYCLES) @(posedge clk);

      a_two_scripts: assert (scripts_done == 2)
         else begin
            $display("FAIL script_count: expected %0d, actual %0d", 2, scripts_done);
            fail_run();
         end
      a_done_held: assert (done)
         else begin
            $display("FAIL done_held: expected 1, actual %0b", done);
            fail_run();
         end

      if ((scripts_done == 2) && done && !check_err) begin
         $display("TEST PASSED");
         $finish;
      end else begin
         fail_run();
      end
   end

endmodule

`default_nettype wire

// ==== dv/lcd_bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_params.svh"

module lcd_bus_checker
   import lcd_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        lcd_e,
   input  logic        lcd_rs,
   input  lcd_nibble_t lcd_data,
   input  logic        done,
   output logic        err,
   output int          scripts_done
);

   localparam int PULSES    = 4 + 2 * (`LCD_SCRIPT_LEN - 4); // E pulses per script
   localparam int CLEAR_LOW = 11;                           // Low nibble of 0x01

   lcd_nibble_t exp_nib [PULSES];
   logic        exp_rs  [PULSES];
   logic        rst_q, e_q, done_q, rs_q, first_rs, gap_armed;
   lcd_nibble_t data_q;
   int          e_len, pulse_idx, start_cnt, gap_cnt;
   logic        seq_err    = 1'b0;
   logic        stable_err = 1'b0;
   logic        quiet_err  = 1'b0;

   assign err = seq_err | stable_err | quiet_err;

   // Expected pulses, from the init, command and message rules
   initial begin
      lcd_byte_t cmd [4];
      lcd_byte_t ch;
      string     msg;
      msg    = "* COLECOVISION *";
      cmd[0] = 8'h28;
      cmd[1] = 8'h06;
      cmd[2] = 8'h0C;
      cmd[3] = 8'h01;
      for (int k = 0; k < 4; k++) begin
         exp_nib[k] = (k == 3) ? 4'h2 : 4'h3;
         exp_rs[k]  = 1'b0;
      end
      for (int k = 0; k < 4; k++) begin    // High half first
         exp_nib[4 + 2 * k] = cmd[k][7:4];
         exp_nib[5 + 2 * k] = cmd[k][3:0];
         exp_rs[4 + 2 * k]  = 1'b0;
         exp_rs[5 + 2 * k]  = 1'b0;
      end
      for (int k = 0; k < 16; k++) begin
         ch                  = msg[k];
         exp_nib[12 + 2 * k] = ch[7:4];
         exp_nib[13 + 2 * k] = ch[3:0];
         exp_rs[12 + 2 * k]  = 1'b1;
         exp_rs[13 + 2 * k]  = 1'b1;
      end
   end

   function automatic string pulse_test(int idx);
      if (idx < 4)  return "init_nibble";
      if (idx < 12) return "command";
      return "message";
   endfunction

   task automatic flag_mismatch(string name, int expected, int actual);
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      seq_err = 1'b1;
   endtask

   always @(posedge clk) begin
      rst_q  <= rst;
      data_q <= lcd_data;
      rs_q   <= lcd_rs;
      if (rst) begin
         e_q          <= 1'b0;
         done_q       <= 1'b0;
         e_len        <= 0;
         pulse_idx    <= 0;
         start_cnt    <= 0;
         gap_cnt      <= 0;
         gap_armed    <= 1'b0;
         first_rs     <= 1'b0;
         scripts_done <= 0;
      end else begin
         e_q       <= lcd_e;
         done_q    <= done;
         e_len     <= lcd_e ? e_len + 1 : 0;   // Samples with E high so far
         start_cnt <= start_cnt + 1;
         gap_cnt   <= gap_cnt + 1;

         if (rst_q) begin   // First cycle out of reset
            a_reset_e: assert (!lcd_e) else flag_mismatch("reset_e", 0, lcd_e);
            a_reset_done: assert (!done) else flag_mismatch("reset_done", 0, done);
         end

         // Rising E
         if (!e_q && lcd_e) begin
            a_powerup: assert (start_cnt >= `LCD_POWERUP_CYCLES)
               else flag_mismatch("powerup_delay", `LCD_POWERUP_CYCLES, start_cnt);
            a_count: assert (pulse_idx < PULSES)
               else flag_mismatch("pulse_count", PULSES, pulse_idx + 1);
            if (gap_armed) begin
               a_long: assert (gap_cnt >= `LCD_LONG_WAIT_CYCLES)
                  else flag_mismatch("long_wait", `LCD_LONG_WAIT_CYCLES, gap_cnt);
               gap_armed <= 1'b0;
            end
         end

         // Falling E, data and RS still held in this cycle
         if (e_q && !lcd_e) begin
            a_e_width: assert (e_len == `LCD_PHASE_CYCLES)
               else flag_mismatch("e_width", `LCD_PHASE_CYCLES, e_len);
            if (pulse_idx < PULSES) begin
               // Compared as {rs, nibble}
               a_nibble: assert ({lcd_rs, lcd_data} == {exp_rs[pulse_idx], exp_nib[pulse_idx]})
                  else flag_mismatch(pulse_test(pulse_idx),
                                     {exp_rs[pulse_idx], exp_nib[pulse_idx]},
                                     {lcd_rs, lcd_data});
               if (pulse_idx >= 4) begin
                  if (((pulse_idx - 4) % 2) == 0) first_rs <= lcd_rs;
                  else begin
                     a_rs_pair: assert (lcd_rs == first_rs)
                        else flag_mismatch("rs_pair", first_rs, lcd_rs);
                  end
               end
            end
            if (pulse_idx == CLEAR_LOW) begin   // Time the post-clear gap
               gap_armed <= 1'b1;
               gap_cnt   <= 0;
            end
            pulse_idx <= pulse_idx + 1;
         end

         if (!done_q && done) begin
            a_done_last: assert (pulse_idx == PULSES)
               else flag_mismatch("done_after_last", PULSES, pulse_idx);
            pulse_idx    <= 0;
            scripts_done <= scripts_done + 1;
         end
         if (done_q && !done) start_cnt <= 0;   // Restart, power-up wait again
      end
   end

   // Panel latches on falling E, nothing may move while it is high
   a_e_stable: assert property (@(posedge clk) disable iff (rst)
      (lcd_e && e_q) |-> ((lcd_data == data_q) && (lcd_rs == rs_q)))
      else begin
         $display("FAIL e_stable: expected %0h, actual %0h",
                  $sampled({rs_q, data_q}), $sampled({lcd_rs, lcd_data}));
         stable_err = 1'b1;
      end

   a_quiet_after_done: assert property (@(posedge clk) disable iff (rst)
      done |-> !lcd_e)
      else begin
         $display("FAIL quiet_after_done: expected 0, actual %0b", $sampled(lcd_e));
         quiet_err = 1'b1;
      end

endmodule

`default_nettype wire

// ==== design/lcd_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_display_top
   import lcd_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        repeat_en, // Rerun script after done
   output logic        lcd_e,
   output logic        lcd_rs,
   output lcd_nibble_t lcd_data,   // DB7..DB4, RW tied low on the board
   output logic        done
);

   lcd_step_idx_t step_idx;
   lcd_step_t     step;       // ROM entry at step_idx
   lcd_step_t     issued;     // Step handed to the writer
   logic          step_valid;
   logic          bus_busy;

   // Script table
   lcd_script_rom u_rom (
      .step_idx (step_idx),
      .step     (step)
   );

   // Ordering and waits
   lcd_sequencer u_seq (
      .clk        (clk),
      .rst        (rst),
      .repeat_en  (repeat_en),
      .bus_busy   (bus_busy),
      .step       (step),
      .step_idx   (step_idx),
      .step_valid (step_valid),
      .issued     (issued),
      .done       (done)
   );

   // Pin timing
   lcd_bus_writer u_bus (
      .clk        (clk),
      .rst        (rst),
      .step_valid (step_valid),
      .issued     (issued),
      .bus_busy   (bus_busy),
      .lcd_e      (lcd_e),
      .lcd_rs     (lcd_rs),
      .lcd_data   (lcd_data)
   );

endmodule

`default_nettype wire

// ==== design/lcd_bus_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_params.svh"

module lcd_bus_writer
   import lcd_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        step_valid,
   input  lcd_step_t   issued,
   output logic        bus_busy,
   output logic        lcd_e,
   output logic        lcd_rs,
   output lcd_nibble_t lcd_data
);

   localparam int PHASE_W = $clog2(`LCD_PHASE_CYCLES + 1);

   typedef logic [PHASE_W-1:0] phase_cnt_t;

   localparam phase_cnt_t PHASE_LOAD = phase_cnt_t'(`LCD_PHASE_CYCLES - 1);

   lcd_bus_state_e state;
   phase_cnt_t     phase_cnt;
   logic           phase_last;
   logic           second_nib; // Low nibble of a byte still to send
   lcd_nibble_t    first_nib;
   lcd_nibble_t    low_nib;    // Held copy for the second pass
   logic           rs_hold;

   assign phase_last = (phase_cnt == '0);

   // Bytes lead with the high half, lone nibbles use the low half
   assign first_nib = (issued.kind == KIND_BYTE) ? issued.code[7:4] : issued.code[3:0];

   // Payload capture
   always_ff @(posedge clk) begin
      if ((state == BUS_IDLE) && step_valid) begin
         low_nib <= issued.code[3:0];
         rs_hold <= issued.rs;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= BUS_IDLE;
         phase_cnt  <= PHASE_LOAD;
         second_nib <= 1'b0;
         bus_busy   <= 1'b0;
         lcd_e      <= 1'b0;
         lcd_rs     <= 1'b0;
         lcd_data   <= '0;
      end else begin
         // Every phase is the same length, reload on each change
         phase_cnt <= ((state == BUS_IDLE) || phase_last) ? PHASE_LOAD : phase_cnt - 1'b1;

         // Pins are set on the edge that enters a phase, so they line up with state
         case (state)
            BUS_IDLE: begin
               if (step_valid) begin
                  state      <= BUS_SETUP;
                  bus_busy   <= 1'b1;
                  second_nib <= (issued.kind == KIND_BYTE);
                  lcd_rs     <= issued.rs;
                  lcd_data   <= first_nib;
               end
            end
            BUS_SETUP: begin
               if (phase_last) begin
                  state <= BUS_E_HIGH;
                  lcd_e <= 1'b1;
               end
            end
            BUS_E_HIGH: begin
               if (phase_last) begin
                  state <= BUS_HOLD;
                  lcd_e <= 1'b0;   // Panel latches on this falling edge
               end
            end
            BUS_HOLD: begin
               if (phase_last) begin
                  state    <= BUS_GAP;
                  lcd_rs   <= 1'b0; // Bus quiet between nibbles
                  lcd_data <= '0;
               end
            end
            BUS_GAP: begin
               if (phase_last) begin
                  if (second_nib) begin
                     state      <= BUS_SETUP;
                     second_nib <= 1'b0;
                     lcd_rs     <= rs_hold;
                     lcd_data   <= low_nib;
                  end else begin
                     state    <= BUS_IDLE;
                     bus_busy <= 1'b0;  // Sequencer may issue next cycle
                  end
               end
            end
            default: state <= BUS_IDLE;
         endcase
      end
   end

   // Panel samples on falling E, so nothing moves while E is up
   a_stable_while_e: assert property (@(posedge clk) disable iff (rst)
      (lcd_e && $past(lcd_e)) |-> ($stable(lcd_data) && $stable(lcd_rs)))
      else $error("lcd_data or lcd_rs changed while lcd_e high");

   a_no_e_in_setup: assert property (@(posedge clk) disable iff (rst)
      (state == BUS_SETUP) |-> !lcd_e)
      else $error("lcd_e high during setup phase");

endmodule

`default_nettype wire

// ==== design/lcd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_params.svh"

module lcd_sequencer
   import lcd_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic          repeat_en,
   input  logic          bus_busy,
   input  lcd_step_t     step,
   output lcd_step_idx_t step_idx,
   output logic          step_valid,
   output lcd_step_t     issued,
   output logic          done
);

   // One down-counter covers both waits, sized for the longer one
   localparam int WAIT_MAX = (`LCD_POWERUP_CYCLES > `LCD_LONG_WAIT_CYCLES) ?
                             `LCD_POWERUP_CYCLES : `LCD_LONG_WAIT_CYCLES;
   localparam int WAIT_W   = $clog2(WAIT_MAX + 1);

   typedef logic [WAIT_W-1:0] wait_cnt_t;

   localparam wait_cnt_t     POWERUP_LOAD = wait_cnt_t'(`LCD_POWERUP_CYCLES - 1);
   localparam wait_cnt_t     LONG_LOAD    = wait_cnt_t'(`LCD_LONG_WAIT_CYCLES - 1);
   localparam lcd_step_idx_t LAST_IDX     = lcd_step_idx_t'(`LCD_SCRIPT_LEN - 1);

   lcd_seq_state_e state;
   wait_cnt_t      wait_cnt;
   logic           long_pending; // Step in flight is the clear command
   logic           last_pending; // Step in flight is the final one
   logic           is_clear;
   logic           chain_next;   // Next step may follow straight on

   assign is_clear   = (step.kind == KIND_BYTE) && !step.rs && (step.code == 8'h01);
   assign chain_next = !long_pending && !last_pending;

   // Issue on the first idle cycle, either after a wait or right behind a step
   assign step_valid = !bus_busy &&
                       ((state == SEQ_ISSUE) || ((state == SEQ_WAIT_BUS) && chain_next));

   assign issued = step;               // ROM output is stable for the whole issue cycle
   assign done   = (state == SEQ_DONE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= SEQ_POWERUP;
         wait_cnt     <= POWERUP_LOAD;
         step_idx     <= '0;
         long_pending <= 1'b0;
         last_pending <= 1'b0;
      end else begin
         // Bookkeeping on every issue
         if (step_valid) begin
            long_pending <= is_clear;
            last_pending <= (step_idx == LAST_IDX);
            if (step_idx != LAST_IDX)
               step_idx <= step_idx + 1'b1; // Parks on the last entry
         end

         case (state)
            SEQ_POWERUP: begin
               if (wait_cnt == '0) state <= SEQ_ISSUE;
               else                wait_cnt <= wait_cnt - 1'b1;
            end
            SEQ_ISSUE: begin
               if (step_valid) state <= SEQ_WAIT_BUS;
            end
            SEQ_WAIT_BUS: begin
               // Busy is already high the cycle after an issue
               if (!bus_busy) begin
                  if (long_pending) begin
                     state    <= SEQ_LONG_WAIT;
                     wait_cnt <= LONG_LOAD;
                  end else if (last_pending) begin
                     state <= SEQ_DONE;
                  end
                  // Otherwise the next step went out this cycle, stay here
               end
            end
            SEQ_LONG_WAIT: begin
               if (wait_cnt == '0) state <= SEQ_ISSUE;
               else                wait_cnt <= wait_cnt - 1'b1;
            end
            SEQ_DONE: begin
               if (repeat_en) begin   // Rerun from the power-up wait
                  state        <= SEQ_POWERUP;
                  wait_cnt     <= POWERUP_LOAD;
                  step_idx     <= '0;
                  last_pending <= 1'b0;
               end
            end
            default: state <= SEQ_POWERUP;
         endcase
      end
   end

   // Writer must go busy right after taking a step, or WAIT_BUS would issue twice
   a_busy_after_issue: assert property (@(posedge clk) disable iff (rst)
      step_valid |=> bus_busy)
      else $error("bus_busy not raised after step_valid");

   // Nothing goes out once the final entry is in flight
   a_issue_in_script: assert property (@(posedge clk) disable iff (rst)
      step_valid |-> !last_pending)
      else $error("Step issued past script end, idx %0d", step_idx);

endmodule

`default_nettype wire

// ==== design/lcd_script_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_params.svh"

module lcd_script_rom
   import lcd_pkg::*;
(
   input  lcd_step_idx_t step_idx,
   output lcd_step_t     step
);

   always_comb begin
      case (step_idx)
         // Power-on init, 8-bit mode three times then switch to 4-bit
         5'd0:  step = '{KIND_NIBBLE, 1'b0, 8'h03};
         5'd1:  step = '{KIND_NIBBLE, 1'b0, 8'h03};
         5'd2:  step = '{KIND_NIBBLE, 1'b0, 8'h03};
         5'd3:  step = '{KIND_NIBBLE, 1'b0, 8'h02}; // Now in 4-bit mode

         // Full commands, two nibbles each
         5'd4:  step = '{KIND_BYTE, 1'b0, 8'h28}; // Function set, 2 lines 5x8
         5'd5:  step = '{KIND_BYTE, 1'b0, 8'h06}; // Entry mode, increment
         5'd6:  step = '{KIND_BYTE, 1'b0, 8'h0C}; // Display on, no cursor
         5'd7:  step = '{KIND_BYTE, 1'b0, 8'h01}; // Clear, slow on the panel

         // Message text, RS high
         5'd8:  step = '{KIND_BYTE, 1'b1, 8'h2A}; // *
         5'd9:  step = '{KIND_BYTE, 1'b1, 8'h20}; // Space
         5'd10: step = '{KIND_BYTE, 1'b1, 8'h43}; // C
         5'd11: step = '{KIND_BYTE, 1'b1, 8'h4F}; // O
         5'd12: step = '{KIND_BYTE, 1'b1, 8'h4C}; // L
         5'd13: step = '{KIND_BYTE, 1'b1, 8'h45}; // E
         5'd14: step = '{KIND_BYTE, 1'b1, 8'h43}; // C
         5'd15: step = '{KIND_BYTE, 1'b1, 8'h4F}; // O
         5'd16: step = '{KIND_BYTE, 1'b1, 8'h56}; // V
         5'd17: step = '{KIND_BYTE, 1'b1, 8'h49}; // I
         5'd18: step = '{KIND_BYTE, 1'b1, 8'h53}; // S
         5'd19: step = '{KIND_BYTE, 1'b1, 8'h49}; // I
         5'd20: step = '{KIND_BYTE, 1'b1, 8'h4F}; // O
         5'd21: step = '{KIND_BYTE, 1'b1, 8'h4E}; // N
         5'd22: step = '{KIND_BYTE, 1'b1, 8'h20}; // Space
         5'd23: step = '{KIND_BYTE, 1'b1, 8'h2A}; // *

         // Past the end, a lone zero nibble with RS low does nothing harmful
         default: step = '{KIND_NIBBLE, 1'b0, 8'h00};
      endcase
   end

   // Sequencer must stop at the last entry and never index past it
   always_comb begin
      if (!$isunknown(step_idx)) begin
         a_idx_in_script: assert (step_idx < `LCD_SCRIPT_LEN)
            else $error("ROM read past script end, idx %0d", step_idx);
      end
   end

endmodule

`default_nettype wire

// ==== design/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

   typedef logic [3:0] lcd_nibble_t;   // 4-bit bus value on DB7..DB4
   typedef logic [7:0] lcd_byte_t;     // Command or character code
   typedef logic [4:0] lcd_step_idx_t; // Script position

   // Nibble steps drive code[3:0] only, byte steps send code[7:4] first
   typedef enum logic {
      KIND_NIBBLE = 1'b0,
      KIND_BYTE   = 1'b1
   } lcd_kind_e;

   // One script entry, 10 bits
   typedef struct packed {
      lcd_kind_e kind;
      logic      rs;   // Low for commands, high for character data
      lcd_byte_t code;
   } lcd_step_t;

   typedef enum logic [2:0] {
      SEQ_POWERUP,   // Settle wait before step 0
      SEQ_ISSUE,     // Hand next step to the writer
      SEQ_WAIT_BUS,  // Writer busy with the step
      SEQ_LONG_WAIT, // Post-clear settle
      SEQ_DONE
   } lcd_seq_state_e;

   // One pass per nibble, BUS_SETUP again for the low half of a byte
   typedef enum logic [2:0] {
      BUS_IDLE,
      BUS_SETUP,
      BUS_E_HIGH,
      BUS_HOLD,
      BUS_GAP
   } lcd_bus_state_e;

endpackage

`default_nettype wire

// ==== include/lcd_params.svh ====
`ifndef LCD_PARAMS_SVH
`define LCD_PARAMS_SVH

// Bus timing, in clk cycles
// Short phases suit simulation; a 50 MHz board wants about 50 per phase
`define LCD_PHASE_CYCLES 4

// Controller power-up settle time before the first init nibble
`define LCD_POWERUP_CYCLES 64

// Extra settle time after the clear command
`define LCD_LONG_WAIT_CYCLES 96

// Script length
// 4 init nibbles + 4 commands + 16 characters
`define LCD_SCRIPT_LEN 24

`endif
